// File: common/shell_glue_pkg.sv
// Shell glue shared definitions

package shell_glue_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned NUM_DDR        = 4;
  localparam int unsigned NUM_STAT_CH    = 3;
  localparam int unsigned NUM_STAT_STGS  = 8;

  // One scrub beat covers a full 512-bit line
  localparam int unsigned LINE_BYTES     = 64;
  localparam int unsigned SCRB_BURST_LEN = 16;

  // Card identity words shown when debug readback is off
  localparam logic [31:0] CL_ID0 = 32'hF010_1D0F;
  localparam logic [31:0] CL_ID1 = 32'h1D51_FEDC;

  // --------------------------------------------------
  // Scrubber memory port (Wishbone classic, write only)
  // --------------------------------------------------
  typedef logic [63:0] scrb_addr_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    scrb_addr_t adr;
  } wb_scrb_m2s_t;

  typedef struct packed {
    logic ack;
  } wb_scrb_s2m_t;

  // --------------------------------------------------
  // DDR controller status links
  // --------------------------------------------------
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } stat_req_t;

  typedef struct packed {
    logic        ack;
    logic [7:0]  irq;
    logic [31:0] rdata;
  } stat_rsp_t;

  // Debug readback selection
  typedef struct packed {
    logic       en;
    logic [2:0] sel;
  } dbg_sel_t;

endpackage

// File: design/ctl_regs.sv
// Shell control word decode

`timescale 1ns/1ps

module ctl_regs
  import shell_glue_pkg::*;
(
  input  logic               clk,
  input  logic               sync_rst_n,
  input  logic [31:0]        ctl0,
  input  logic               flr_assert,
  output logic [NUM_DDR-1:0] scrb_en,
  output dbg_sel_t           dbg,
  output logic               flr_done
);

  // Control word layout
  localparam int unsigned DBG_EN_BIT  = 31;
  localparam int unsigned DBG_SEL_LSB = 28;

  logic flr_q;

  // --------------------------------------------------
  // Control word capture
  // --------------------------------------------------
  // Only the decoded fields are kept, bits 27:4 are reserved
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      scrb_en <= '0;
      dbg     <= '0;
    end
    else
    begin
      scrb_en <= ctl0[NUM_DDR-1:0];
      dbg     <= '{en: ctl0[DBG_EN_BIT], sel: ctl0[DBG_SEL_LSB +: 3]};
    end
  end

  // --------------------------------------------------
  // Function-level reset acknowledge
  // --------------------------------------------------
  // Request is registered first, then acknowledged.
  // A held request makes the acknowledge toggle
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_q    <= 1'b0;
      flr_done <= 1'b0;
    end
    else
    begin
      flr_q    <= flr_assert;
      flr_done <= flr_q && !flr_done;
    end
  end

endmodule

// File: scrub/ddr_scrubber.sv
// DDR zero-fill scrubber

`timescale 1ns/1ps

module ddr_scrubber
  import shell_glue_pkg::*;
#(
  parameter scrb_addr_t SCRB_MAX_ADDR = 64'h3FFFFFFFF
) (
  input  logic         clk,
  input  logic         sync_rst_n,
  input  logic         enable,
  input  wb_scrb_s2m_t wb_in,
  output wb_scrb_m2s_t wb_out,
  output scrb_addr_t   scrb_addr,
  output logic         done
);

  localparam int unsigned BEAT_W    = $clog2(SCRB_BURST_LEN);
  // Start address of the final line in range
  localparam scrb_addr_t  LAST_ADDR = SCRB_MAX_ADDR - scrb_addr_t'(LINE_BYTES - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BEAT,
    S_GAP,
    S_DONE
  } scrb_state_t;

  scrb_state_t       state;
  scrb_addr_t        addr;
  logic [BEAT_W-1:0] beat_cnt;
  logic              last_beat;
  logic              burst_end;

  assign last_beat = (addr >= LAST_ADDR);
  assign burst_end = (beat_cnt == BEAT_W'(SCRB_BURST_LEN - 1));

  // --------------------------------------------------
  // Burst sequencer
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state    <= S_IDLE;
      addr     <= '0;
      beat_cnt <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (enable)
            state <= S_BEAT;
        end

        S_BEAT:
        begin
          // A beat in flight always finishes before we leave
          if (wb_in.ack)
          begin
            if (!enable)
            begin
              state    <= S_IDLE;
              addr     <= '0;
              beat_cnt <= '0;
            end
            else if (last_beat)
              state <= S_DONE;
            else
            begin
              addr     <= addr + scrb_addr_t'(LINE_BYTES);
              beat_cnt <= beat_cnt + 1'b1;
              if (burst_end)
                state <= S_GAP;
            end
          end
        end

        // cyc is low here for one cycle between bursts
        S_GAP:
        begin
          if (enable)
            state <= S_BEAT;
          else
          begin
            state    <= S_IDLE;
            addr     <= '0;
            beat_cnt <= '0;
          end
        end

        default:
        begin
          if (!enable)
          begin
            state    <= S_IDLE;
            addr     <= '0;
            beat_cnt <= '0;
          end
        end
      endcase
    end
  end

  // Classic cycle, so stb and cyc move together
  assign wb_out.cyc = (state == S_BEAT);
  assign wb_out.stb = (state == S_BEAT);
  assign wb_out.adr = addr;

  assign scrb_addr = addr;
  assign done      = (state == S_DONE);

endmodule

// File: design/id_readback.sv
// ID outputs with debug readback

`timescale 1ns/1ps

module id_readback
  import shell_glue_pkg::*;
(
  input  logic        clk,
  input  logic        sync_rst_n,
  input  dbg_sel_t    dbg,
  input  scrb_addr_t  scrb_addr [NUM_DDR],
  output logic [31:0] id0,
  output logic [31:0] id1
);

  localparam int unsigned CH_W = $clog2(NUM_DDR);

  logic [CH_W-1:0] ch;
  scrb_addr_t      sel_addr;

  // Out-of-range select falls back to channel 0
  assign ch       = (dbg.sel < 3'(NUM_DDR)) ? dbg.sel[CH_W-1:0] : '0;
  assign sel_addr = scrb_addr[ch];

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      id0 <= CL_ID0;
      id1 <= CL_ID1;
    end
    else if (dbg.en)
    begin
      id0 <= sel_addr[31:0];
      id1 <= sel_addr[63:32];
    end
    else
    begin
      id0 <= CL_ID0;
      id1 <= CL_ID1;
    end
  end

endmodule

// File: stat/stat_pipe.sv
// Status link delay line

`timescale 1ns/1ps

module stat_pipe #(
  parameter type         T      = logic,
  parameter int unsigned STAGES = 1
) (
  input  logic clk,
  input  logic sync_rst_n,
  input  T     d,
  output T     q
);

  T pipe_q [STAGES];

  // Plain shift chain, every stage clears on reset
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
        pipe_q[i] <= '0;
    end
    else
    begin
      pipe_q[0] <= d;
      for (int i = 1; i < STAGES; i++)
        pipe_q[i] <= pipe_q[i-1];
    end
  end

  assign q = pipe_q[STAGES-1];

endmodule

// File: design/cl_shell_glue.sv
// Custom logic shell glue top

`timescale 1ns/1ps

module cl_shell_glue
  import shell_glue_pkg::*;
#(
  parameter scrb_addr_t  SCRB_MAX_ADDR = 64'h3FFFFFFFF,
  parameter int unsigned STAT_STGS     = NUM_STAT_STGS
) (
  input  logic               clk,
  input  logic               sync_rst_n,

  // Shell control
  input  logic [31:0]        ctl0,
  input  logic               flr_assert,
  output logic               flr_done,
  output logic [31:0]        id0,
  output logic [31:0]        id1,

  // Scrubber memory ports
  input  wb_scrb_s2m_t       scrb_wb_in   [NUM_DDR],
  output wb_scrb_m2s_t       scrb_wb_out  [NUM_DDR],
  output logic [NUM_DDR-1:0] scrb_done,

  // Status links, shell side in and controller side out
  input  stat_req_t          stat_req_in  [NUM_STAT_CH],
  output stat_req_t          stat_req_out [NUM_STAT_CH],
  input  stat_rsp_t          stat_rsp_in  [NUM_STAT_CH],
  output stat_rsp_t          stat_rsp_out [NUM_STAT_CH]
);

  logic [NUM_DDR-1:0] scrb_en;
  dbg_sel_t           dbg;
  scrb_addr_t         scrb_addr [NUM_DDR];

  // --------------------------------------------------
  // Control word
  // --------------------------------------------------
  ctl_regs ctl_regs_inst (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .ctl0       (ctl0),
    .flr_assert (flr_assert),
    .scrb_en    (scrb_en),
    .dbg        (dbg),
    .flr_done   (flr_done)
  );

  // --------------------------------------------------
  // Per-channel scrubbers
  // --------------------------------------------------
  for (genvar ch = 0; ch < NUM_DDR; ch++)
  begin : g_scrb
    ddr_scrubber #(
      .SCRB_MAX_ADDR (SCRB_MAX_ADDR)
    ) ddr_scrubber_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .enable     (scrb_en[ch]),
      .wb_in      (scrb_wb_in[ch]),
      .wb_out     (scrb_wb_out[ch]),
      .scrb_addr  (scrb_addr[ch]),
      .done       (scrb_done[ch])
    );
  end

  // Debug view of the scrub addresses
  id_readback id_readback_inst (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .dbg        (dbg),
    .scrb_addr  (scrb_addr),
    .id0        (id0),
    .id1        (id1)
  );

  // --------------------------------------------------
  // Status pipelines, one pair per controller
  // --------------------------------------------------
  for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
  begin : g_stat
    stat_pipe #(
      .T      (stat_req_t),
      .STAGES (STAT_STGS)
    ) req_pipe_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .d          (stat_req_in[ch]),
      .q          (stat_req_out[ch])
    );

    stat_pipe #(
      .T      (stat_rsp_t),
      .STAGES (STAT_STGS)
    ) rsp_pipe_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .d          (stat_rsp_in[ch]),
      .q          (stat_rsp_out[ch])
    );
  end

endmodule

// File: sim/cl_shell_glue_assert.sv
// Scrubber bus protocol checks

`timescale 1ns/1ps

module cl_shell_glue_assert
  import shell_glue_pkg::*;
(
  input logic               clk,
  input logic               sync_rst_n,
  input wb_scrb_m2s_t       scrb_wb_out [NUM_DDR],
  input wb_scrb_s2m_t       scrb_wb_in  [NUM_DDR],
  input logic [NUM_DDR-1:0] scrb_done
);

  // Failed assertion count
  int unsigned fail_cnt = 0;

  for (genvar ch = 0; ch < NUM_DDR; ch++)
  begin : g_chk
    // A strobe is only valid inside a bus cycle
    a_stb_in_cyc : assert property (@(posedge clk) disable iff (!sync_rst_n)
      scrb_wb_out[ch].stb |-> scrb_wb_out[ch].cyc)
      else
      begin
        $error("stb high without cyc on channel %0d", ch);
        fail_cnt++;
      end

    // Address holds until the beat is acked
    a_adr_hold : assert property (@(posedge clk) disable iff (!sync_rst_n)
      (scrb_wb_out[ch].stb && !scrb_wb_in[ch].ack) |=> $stable(scrb_wb_out[ch].adr))
      else
      begin
        $error("adr changed before ack on channel %0d", ch);
        fail_cnt++;
      end

    // Done only follows the last beat
    a_done_idle : assert property (@(posedge clk) disable iff (!sync_rst_n)
      $rose(scrb_done[ch]) |-> !scrb_wb_out[ch].stb)
      else
      begin
        $error("done rose with stb high on channel %0d", ch);
        fail_cnt++;
      end
  end

endmodule

bind cl_shell_glue cl_shell_glue_assert cl_shell_glue_assert_inst (
  .clk         (clk),
  .sync_rst_n  (sync_rst_n),
  .scrb_wb_out (scrb_wb_out),
  .scrb_wb_in  (scrb_wb_in),
  .scrb_done   (scrb_done)
);

// File: sim/tb_cl_shell_glue.sv
// Shell glue directed testbench

`timescale 1ns/1ps

module tb_cl_shell_glue
  import shell_glue_pkg::*;
;

  localparam scrb_addr_t  MAX_ADDR  = 64'h7FF;
  localparam int unsigned BEATS     = (MAX_ADDR + 1) / LINE_BYTES;
  localparam int unsigned STGS      = NUM_STAT_STGS;
  localparam int unsigned STAT_VECS = 20;
  localparam int unsigned LOG_DEPTH = 256;
  localparam int unsigned TIMEOUT   = 2000;

  logic               clk;
  logic               sync_rst_n;
  logic [31:0]        ctl0;
  logic               flr_assert;
  logic               flr_done;
  logic [31:0]        id0;
  logic [31:0]        id1;
  wb_scrb_s2m_t       scrb_wb_in   [NUM_DDR];
  wb_scrb_m2s_t       scrb_wb_out  [NUM_DDR];
  logic [NUM_DDR-1:0] scrb_done;
  stat_req_t          stat_req_in  [NUM_STAT_CH];
  stat_req_t          stat_req_out [NUM_STAT_CH];
  stat_rsp_t          stat_rsp_in  [NUM_STAT_CH];
  stat_rsp_t          stat_rsp_out [NUM_STAT_CH];

  // Responder state and beat log
  logic [31:0] rng_state = 32'hbb4321f5;
  int          ack_wait [NUM_DDR];
  int          beat_cnt [NUM_DDR];
  scrb_addr_t  beat_log [NUM_DDR][LOG_DEPTH];
  logic        stall_en;
  int          stall_ch;
  scrb_addr_t  stall_addr;
  int          err_cnt;
  int          test_cnt;
  int          fail_tests;

  cl_shell_glue #(
    .SCRB_MAX_ADDR (MAX_ADDR),
    .STAT_STGS     (STGS)
  ) cl_shell_glue_inst (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .flr_assert   (flr_assert),
    .flr_done     (flr_done),
    .id0          (id0),
    .id1          (id1),
    .scrb_wb_in   (scrb_wb_in),
    .scrb_wb_out  (scrb_wb_out),
    .scrb_done    (scrb_done),
    .stat_req_in  (stat_req_in),
    .stat_req_out (stat_req_out),
    .stat_rsp_in  (stat_rsp_in),
    .stat_rsp_out (stat_rsp_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // --------------------------------------------------
  // Memory responder per channel
  // --------------------------------------------------
  always @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
        scrb_wb_in[ch].ack <= 1'b0;
        ack_wait[ch]       <= 0;
        beat_cnt[ch]       <= 0;
      end
    end
    else
    begin
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
        if (scrb_wb_out[ch].stb && scrb_wb_in[ch].ack)
        begin
          // Beat completes on this edge
          if (beat_cnt[ch] < LOG_DEPTH)
            beat_log[ch][beat_cnt[ch]] <= scrb_wb_out[ch].adr;
          beat_cnt[ch]       <= beat_cnt[ch] + 1;
          scrb_wb_in[ch].ack <= 1'b0;
          ack_wait[ch]       <= int'(lcg_next() >> 30);
        end
        else if (scrb_wb_out[ch].stb &&
                 !(stall_en && stall_ch == ch && scrb_wb_out[ch].adr == stall_addr))
        begin
          if (ack_wait[ch] == 0)
            scrb_wb_in[ch].ack <= 1'b1;
          else
            ack_wait[ch] <= ack_wait[ch] - 1;
        end
      end
    end
  end

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(string msg);
    $display("ERROR: %s", msg);
    err_cnt++;
  endtask

  task automatic finish_test(string name, int err_start);
    test_cnt++;
    if (err_cnt == err_start)
      $display("%-18s ok", name);
    else
    begin
      fail_tests++;
      $display("%-18s FAILED with %0d errors", name, err_cnt - err_start);
    end
  endtask

  task automatic wait_done(logic [NUM_DDR-1:0] mask, logic level);
    logic [NUM_DDR-1:0] target;
    int                 n;
    target = level ? mask : '0;
    n      = 0;
    while ((scrb_done & mask) !== target && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
    end
    if ((scrb_done & mask) !== target)
      report_error($sformatf("timeout waiting for done 0x%h to reach %b", mask, level));
  endtask

  task automatic check_sequence(int ch, int start);
    scrb_addr_t exp;
    if (beat_cnt[ch] - start != BEATS)
      report_mismatch($sformatf("beat count ch%0d", ch), beat_cnt[ch] - start, BEATS);
    for (int i = 0; i < BEATS && start + i < LOG_DEPTH; i++)
    begin
      exp = scrb_addr_t'(i) * LINE_BYTES;
      if (beat_log[ch][start+i] !== exp)
        report_mismatch($sformatf("scrb_wb_out[%0d].adr", ch), beat_log[ch][start+i], exp);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic reset_state_test();
    int err_start;
    err_start = err_cnt;
    for (int ch = 0; ch < NUM_DDR; ch++)
    begin
      if ({scrb_wb_out[ch].cyc, scrb_wb_out[ch].stb} !== 2'b00)
        report_mismatch($sformatf("scrb_wb_out[%0d].cyc/stb", ch),
                        {scrb_wb_out[ch].cyc, scrb_wb_out[ch].stb}, 0);
    end
    if (scrb_done !== '0)
      report_mismatch("scrb_done", scrb_done, 0);
    if (flr_done !== 1'b0)
      report_mismatch("flr_done", flr_done, 0);
    for (int ch = 0; ch < NUM_STAT_CH; ch++)
    begin
      if (stat_req_out[ch] !== '0)
        report_mismatch($sformatf("stat_req_out[%0d]", ch), stat_req_out[ch], 0);
      if (stat_rsp_out[ch] !== '0)
        report_mismatch($sformatf("stat_rsp_out[%0d]", ch), stat_rsp_out[ch], 0);
    end
    if (id0 !== CL_ID0)
      report_mismatch("id0", id0, CL_ID0);
    if (id1 !== CL_ID1)
      report_mismatch("id1", id1, CL_ID1);
    finish_test("reset state", err_start);
  endtask

  task automatic flr_test();
    int err_start;
    int pulses;
    int first;
    err_start = err_cnt;
    pulses    = 0;
    first     = -1;
    @(posedge clk);
    flr_assert <= 1'b1;
    // Edge 1 registers the request, edge 2 acks, edge 3 sees the pulse
    for (int k = 1; k <= 8; k++)
    begin
      @(posedge clk);
      if (k == 1)
        flr_assert <= 1'b0;
      if (flr_done === 1'b1)
      begin
        pulses++;
        if (first < 0)
          first = k;
      end
    end
    if (pulses != 1)
      report_mismatch("flr_done pulse count", pulses, 1);
    if (first != 3)
      report_mismatch("flr_done pulse edge", first, 3);
    finish_test("flr pulse", err_start);
  endtask

  task automatic stat_pipe_test();
    int          err_start;
    logic [63:0] r;
    stat_req_t   req_hist [STAT_VECS][NUM_STAT_CH];
    stat_rsp_t   rsp_hist [STAT_VECS][NUM_STAT_CH];
    err_start = err_cnt;
    for (int cyc = 0; cyc <= STAT_VECS + STGS; cyc++)
    begin
      @(posedge clk);
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
        // Driven on edge i, captured on edge i+1, at q for sampling on edge i+STGS+1
        if (cyc > STGS && cyc - STGS - 1 < STAT_VECS)
        begin
          if (stat_req_out[ch] !== req_hist[cyc-STGS-1][ch])
            report_mismatch($sformatf("stat_req_out[%0d]", ch), stat_req_out[ch],
                            req_hist[cyc-STGS-1][ch]);
          if (stat_rsp_out[ch] !== rsp_hist[cyc-STGS-1][ch])
            report_mismatch($sformatf("stat_rsp_out[%0d]", ch), stat_rsp_out[ch],
                            rsp_hist[cyc-STGS-1][ch]);
        end
        if (cyc < STAT_VECS)
        begin
          r = {lcg_next(), lcg_next()};
          req_hist[cyc][ch] = r[$bits(stat_req_t)-1:0];
          r = {lcg_next(), lcg_next()};
          rsp_hist[cyc][ch] = r[$bits(stat_rsp_t)-1:0];
          stat_req_in[ch] <= req_hist[cyc][ch];
          stat_rsp_in[ch] <= rsp_hist[cyc][ch];
        end
        else
        begin
          stat_req_in[ch] <= '0;
          stat_rsp_in[ch] <= '0;
        end
      end
    end
    finish_test("status pipeline", err_start);
  endtask

  task automatic full_scrub_test(int ch);
    int   err_start;
    int   start;
    int   bursts;
    int   n;
    logic prev_cyc;
    logic other_busy;
    logic late_beat;
    err_start  = err_cnt;
    start      = beat_cnt[ch];
    bursts     = 0;
    n          = 0;
    prev_cyc   = 1'b0;
    other_busy = 1'b0;
    late_beat  = 1'b0;
    @(posedge clk);
    ctl0 <= 32'(1) << ch;
    while (scrb_done[ch] !== 1'b1 && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
      if (scrb_wb_out[ch].cyc && !prev_cyc)
        bursts++;
      prev_cyc = scrb_wb_out[ch].cyc;
      for (int o = 0; o < NUM_DDR; o++)
      begin
        if (o != ch && scrb_wb_out[o].cyc !== 1'b0)
          other_busy = 1'b1;
      end
    end
    if (scrb_done[ch] !== 1'b1)
      report_error($sformatf("timeout waiting for scrub done on channel %0d", ch));
    // No stray beats once done is high
    repeat (8)
    begin
      @(posedge clk);
      if (scrb_wb_out[ch].cyc !== 1'b0)
        late_beat = 1'b1;
    end
    if (late_beat)
      report_error($sformatf("channel %0d issued a cycle after done", ch));
    if (other_busy)
      report_error($sformatf("another channel issued cycles while scrubbing %0d", ch));
    if (bursts != BEATS / SCRB_BURST_LEN)
      report_mismatch("burst count", bursts, BEATS / SCRB_BURST_LEN);
    check_sequence(ch, start);
    ctl0 <= '0;
    wait_done(NUM_DDR'(1) << ch, 1'b0);
    finish_test($sformatf("full scrub ch%0d", ch), err_start);
  endtask

  task automatic debug_readback_test(int ch, int beat);
    int         err_start;
    int         start;
    int         n;
    scrb_addr_t target;
    err_start = err_cnt;
    start     = beat_cnt[ch];
    target    = scrb_addr_t'(beat) * LINE_BYTES;
    n         = 0;
    @(posedge clk);
    stall_ch   <= ch;
    stall_addr <= target;
    stall_en   <= 1'b1;
    ctl0       <= 32'(1) << ch;
    while (!(scrb_wb_out[ch].stb && scrb_wb_out[ch].adr == target) && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
    end
    if (!(scrb_wb_out[ch].stb && scrb_wb_out[ch].adr == target))
      report_error($sformatf("timeout waiting for beat 0x%h on channel %0d", target, ch));
    ctl0 <= {1'b1, 3'(ch), 24'h0, 4'(1 << ch)};
    // Control register then ID register make it visible on the third edge
    repeat (3) @(posedge clk);
    if (id0 !== target[31:0])
      report_mismatch("id0", id0, target[31:0]);
    if (id1 !== target[63:32])
      report_mismatch("id1", id1, target[63:32]);
    ctl0 <= 32'(1) << ch;
    repeat (3) @(posedge clk);
    if (id0 !== CL_ID0)
      report_mismatch("id0", id0, CL_ID0);
    if (id1 !== CL_ID1)
      report_mismatch("id1", id1, CL_ID1);
    stall_en <= 1'b0;
    wait_done(NUM_DDR'(1) << ch, 1'b1);
    check_sequence(ch, start);
    ctl0 <= '0;
    wait_done(NUM_DDR'(1) << ch, 1'b0);
    finish_test("debug readback", err_start);
  endtask

  task automatic concurrent_scrub_test();
    int err_start;
    int starts [NUM_DDR];
    err_start = err_cnt;
    for (int ch = 0; ch < NUM_DDR; ch++)
      starts[ch] = beat_cnt[ch];
    @(posedge clk);
    ctl0 <= 32'((1 << NUM_DDR) - 1);
    wait_done('1, 1'b1);
    for (int ch = 0; ch < NUM_DDR; ch++)
      check_sequence(ch, starts[ch]);
    ctl0 <= '0;
    wait_done('1, 1'b0);
    finish_test("concurrent scrub", err_start);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    sync_rst_n = 1'b0;
    ctl0       = '0;
    flr_assert = 1'b0;
    stall_en   = 1'b0;
    stall_ch   = 0;
    stall_addr = '0;
    err_cnt    = 0;
    test_cnt   = 0;
    fail_tests = 0;
    for (int ch = 0; ch < NUM_DDR; ch++)
      scrb_wb_in[ch] = '0;
    for (int ch = 0; ch < NUM_STAT_CH; ch++)
    begin
      stat_req_in[ch] = '0;
      stat_rsp_in[ch] = '0;
    end
    repeat (10) @(posedge clk);
    sync_rst_n <= 1'b1;
    @(posedge clk);

    reset_state_test();
    flr_test();
    stat_pipe_test();
    for (int ch = 0; ch < NUM_DDR; ch++)
      full_scrub_test(ch);
    debug_readback_test(2, 5);
    concurrent_scrub_test();

    if (cl_shell_glue_inst.cl_shell_glue_assert_inst.fail_cnt != 0)
      report_error($sformatf("%0d bus protocol assertions failed",
                             cl_shell_glue_inst.cl_shell_glue_assert_inst.fail_cnt));

    $display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: cl_shell_glue.f
common/shell_glue_pkg.sv
design/ctl_regs.sv
scrub/ddr_scrubber.sv
design/id_readback.sv
stat/stat_pipe.sv
design/cl_shell_glue.sv
sim/cl_shell_glue_assert.sv
sim/tb_cl_shell_glue.sv
